/* Makefile */
# Verilator build, run, lint and clean for the memory and IO subsystem

VERILATOR ?= verilator
TOP       ?= soc_io_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
verilog/soc_io_pkg.sv
verilog/apb_io_fsm.sv
verilog/word_ram.sv
verilog/serial_clk_divider.sv
verilog/matrix_shifter.sv
verilog/io_regs.sv
verilog/soc_io_top.sv
verif/soc_io_checker.sv
verif/soc_io_tb.sv

/* verif/soc_io_checker.sv */
// concurrent assertions on the APB slave handshake, the write stall
// and the matrix serial port, bound into the subsystem top
`default_nettype none

module soc_io_checker (
  input logic                   clk,
  input logic                   RESET,
  input logic                   psel,
  input logic                   penable,
  input logic                   pwrite,
  input logic                   pready,
  input logic                   pslverr,
  input logic                   mtx_clk,
  input logic                   mtx_cs,
  input soc_io_pkg::apb_state_t fsm_state
);
  import soc_io_pkg::*;

  // assertion failures seen so far
  int unsigned fail_count = 0;

  // pready only in the access phase
  ready_in_access: assert property (@(posedge clk) disable iff (!RESET)
    pready |-> psel && penable)
    else begin
      $error("pready high outside an APB access phase");
      fail_count++;
    end

  // one response cycle per transfer
  ready_one_cycle: assert property (@(posedge clk) disable iff (!RESET)
    pready |=> !pready)
    else begin
      $error("pready held high for more than one cycle");
      fail_count++;
    end

  err_with_ready: assert property (@(posedge clk) disable iff (!RESET)
    pslverr |-> pready)
    else begin
      $error("pslverr high without pready");
      fail_count++;
    end

  // a stall only holds back a pending write
  stall_on_write: assert property (@(posedge clk) disable iff (!RESET)
    (fsm_state == STALL) |-> psel && penable && pwrite)
    else begin
      $error("FSM stalled without a pending APB write");
      fail_count++;
    end

  // serial clock pulses only inside a chip select window
  sclk_in_frame: assert property (@(posedge clk) disable iff (!RESET)
    mtx_clk |-> !mtx_cs)
    else begin
      $error("mtx_clk pulse while mtx_cs is high");
      fail_count++;
    end

endmodule

bind soc_io_top soc_io_checker soc_io_checker_inst (
  .clk       (clk),
  .RESET     (RESET),
  .psel      (psel),
  .penable   (penable),
  .pwrite    (pwrite),
  .pready    (pready),
  .pslverr   (pslverr),
  .mtx_clk   (mtx_clk),
  .mtx_cs    (mtx_cs),
  .fsm_state (apb_io_fsm_inst.state)
);

`default_nettype wire

/* verif/soc_io_tb.sv */
// testbench for the memory and IO subsystem with APB driver tasks, reference model,
// serial monitor, random tests and reporting
`default_nettype none

module soc_io_tb;
  import soc_io_pkg::*;

  localparam int RAM_ADDR_W = 8;
  localparam int DIV_RATIO  = 4;
  localparam int AW         = RAM_ADDR_W + 3;
  localparam int N_RAM      = 200;
  localparam int N_LED      = 20;
  localparam int N_BTN      = 20;
  localparam int N_MTX      = 4;
  localparam int N_ERR      = 16;
  // transfers and serial words over all tests
  localparam int N_XFER      = 2*N_RAM + 2*N_LED + N_BTN + 3*N_MTX + 3 + 2*N_ERR;
  localparam int N_WORDS     = N_MTX + 2;
  localparam int WORD_CYCLES = MTX_BITS * DIV_RATIO;
  localparam int CYCLE_LIMIT = 2 * (N_XFER*3 + N_WORDS*WORD_CYCLES);
  localparam int XFER_WAIT   = 4 * WORD_CYCLES;

  logic          clk;
  logic          RESET;
  logic          psel;
  logic          penable;
  logic          pwrite;
  logic [AW-1:0] paddr;
  word_t         pwdata;
  strb_t         pstrb;
  word_t         prdata;
  logic          pready;
  logic          pslverr;
  button_t       buttons;
  led_t          leds;
  logic          mtx_din;
  logic          mtx_clk;
  logic          mtx_cs;

  // reference model
  word_t                 ram_model [1 << RAM_ADDR_W];
  bit                    ram_valid [1 << RAM_ADDR_W];
  logic [RAM_ADDR_W-1:0] written_q [$];
  led_t                  led_model;
  mtx_word_t             sent_q [$];

  integer    seed = 69;
  int        errors = 0;
  int        checks = 0;
  int        tests_run = 0;
  int        cycle_count = 0;
  mtx_word_t shift_acc;
  int        bits_seen = 0;
  logic      cs_high_since_word = 1'b1;

  soc_io_top soc_io_top_inst (
    .clk     (clk),
    .RESET   (RESET),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .buttons (buttons),
    .leds    (leds),
    .mtx_din (mtx_din),
    .mtx_clk (mtx_clk),
    .mtx_cs  (mtx_cs)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("ERROR run stopped after %0d cycles without finishing", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string name, input word_t exp, input word_t got);
    checks++;
    assert (got === exp) else begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    checks++;
    assert (got === exp) else begin
      $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic report_error(input string what);
    $display("ERROR t=%0t %s", $time, what);
    errors++;
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests_run++;
    $display("test %-16s done, %0d errors", name, errors - start_errors);
  endtask

  function automatic logic [AW-1:0] ram_addr(input logic [RAM_ADDR_W-1:0] waddr);
    return {1'b0, waddr, 2'b00};
  endfunction

  function automatic logic [AW-1:0] io_addr(input io_sel_t sel);
    return {1'b1, {(RAM_ADDR_W-4){1'b0}}, sel, 2'b00};
  endfunction

  // drives the setup cycle and the access cycles until pready,
  // starting one time unit after a posedge
  task automatic apb_access(input logic wr, input logic [AW-1:0] addr, input word_t data,
                            input strb_t strb, output word_t rdata, output logic err);
    int waited;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    pstrb   = strb;
    waited  = 0;
    @(posedge clk);
    #1 penable = 1'b1;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!pready && waited < XFER_WAIT);
    assert (pready) else report_error("no pready from the DUT within the transfer limit");
    rdata = prdata;
    err   = pslverr;
    // the transfer completes at this edge
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [AW-1:0] addr, input word_t data, input strb_t strb,
                           output logic err);
    word_t rd_ignored;
    apb_access(1'b1, addr, data, strb, rd_ignored, err);
  endtask

  task automatic apb_read(input logic [AW-1:0] addr, output word_t data, output logic err);
    apb_access(1'b0, addr, '0, '0, data, err);
  endtask

  task automatic wait_serial_idle();
    int waited;
    waited = 0;
    while ((!mtx_cs || sent_q.size() != 0) && waited < 2*N_WORDS*WORD_CYCLES) begin
      @(posedge clk);
      #1;
      waited++;
    end
    assert (mtx_cs && sent_q.size() == 0)
      else report_error("matrix transfer did not finish with the expected words");
  endtask

  // mtx_clk is high for a whole cycle so the serial monitor samples at the negedge
  always @(negedge clk) begin
    if (mtx_cs) begin
      assert (bits_seen == 0)
        else report_error("chip select rose in the middle of a matrix word");
      bits_seen = 0;
      cs_high_since_word = 1'b1;
    end
    if (mtx_clk) begin
      assert (cs_high_since_word)
        else report_error("matrix word began without chip select going high");
      shift_acc = {shift_acc[MTX_BITS-2:0], mtx_din};
      bits_seen++;
      if (bits_seen == MTX_BITS) begin
        bits_seen = 0;
        cs_high_since_word = 1'b0;
        assert (sent_q.size() != 0)
          else report_error("matrix word received but none was sent");
        if (sent_q.size() != 0) begin
          check_value("mtx_word", word_t'(sent_q.pop_front()), word_t'(shift_acc));
        end
      end
    end
  end

  initial begin
    word_t                 rdata;
    word_t                 data;
    strb_t                 strb;
    logic                  err;
    logic [RAM_ADDR_W-1:0] waddr;
    io_sel_t               sel;
    int                    start_errors;
    int                    checker_fails;
    clk       = 1'b0;
    RESET     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    pstrb     = '0;
    buttons   = '0;
    led_model = '0;
    repeat (10) @(posedge clk);
    #1 RESET = 1'b1;

    start_errors = errors;
    check_flag("pready", 1'b0, pready);
    check_flag("pslverr", 1'b0, pslverr);
    check_flag("mtx_clk", 1'b0, mtx_clk);
    check_flag("mtx_cs", 1'b1, mtx_cs);
    check_value("leds", 32'd0, word_t'(leds));
    finish_test("reset_values", start_errors);

    // a first write fills the whole word so later partial writes are known
    start_errors = errors;
    for (int i = 0; i < N_RAM; i++) begin
      waddr = RAM_ADDR_W'($random(seed));
      data  = $random(seed);
      strb  = ram_valid[waddr] ? 4'($random(seed)) : 4'hF;
      ram_valid[waddr] = 1'b1;
      for (int lane = 0; lane < 4; lane++) begin
        if (strb[lane]) begin
          ram_model[waddr][lane*8 +: 8] = data[lane*8 +: 8];
        end
      end
      written_q.push_back(waddr);
      apb_write(ram_addr(waddr), data, strb, err);
      check_flag("pslverr", 1'b0, err);
    end
    foreach (written_q[i]) begin
      apb_read(ram_addr(written_q[i]), rdata, err);
      check_value("prdata", ram_model[written_q[i]], rdata);
      check_flag("pslverr", 1'b0, err);
    end
    finish_test("ram_byte_lanes", start_errors);

    start_errors = errors;
    for (int i = 0; i < N_LED; i++) begin
      data = $random(seed);
      apb_write(io_addr(io_sel_t'(1 << LEDS_BIT)), data, 4'hF, err);
      led_model = data[3:0];
      check_flag("pslverr", 1'b0, err);
      check_value("leds", word_t'(led_model), word_t'(leds));
      apb_read(io_addr(io_sel_t'(1 << LEDS_BIT)), rdata, err);
      check_value("prdata", word_t'(led_model), rdata);
    end
    finish_test("led_register", start_errors);

    start_errors = errors;
    for (int i = 0; i < N_BTN; i++) begin
      buttons = 6'($random(seed));
      apb_read(io_addr(io_sel_t'(1 << BUTTONS_BIT)), rdata, err);
      check_value("prdata", {26'd0, buttons}, rdata);
      check_flag("pslverr", 1'b0, err);
    end
    finish_test("button_read", start_errors);

    start_errors = errors;
    for (int i = 0; i < N_MTX; i++) begin
      data = $random(seed);
      sent_q.push_back(data[15:0]);
      apb_write(io_addr(io_sel_t'(1 << MTX_DAT_BIT)), data, 4'hF, err);
      check_flag("pslverr", 1'b0, err);
      apb_read(io_addr(io_sel_t'(1 << MTX_CNTL_BIT)), rdata, err);
      check_value("mtx_busy", 32'd1, rdata);
      wait_serial_idle();
      apb_read(io_addr(io_sel_t'(1 << MTX_CNTL_BIT)), rdata, err);
      check_value("mtx_busy", 32'd0, rdata);
    end
    finish_test("matrix_transfer", start_errors);

    // the second write stalls until the first word is out
    start_errors = errors;
    for (int k = 0; k < 2; k++) begin
      data = $random(seed);
      sent_q.push_back(data[15:0]);
      apb_write(io_addr(io_sel_t'(1 << MTX_DAT_BIT)), data, 4'hF, err);
      check_flag("pslverr", 1'b0, err);
    end
    wait_serial_idle();
    apb_read(io_addr(io_sel_t'(1 << MTX_CNTL_BIT)), rdata, err);
    check_value("mtx_busy", 32'd0, rdata);
    finish_test("back_pressure", start_errors);

    start_errors = errors;
    for (int i = 0; i < N_ERR; i++) begin
      do begin
        sel = 4'($random(seed));
      end while ($countones(sel) == 1);
      data = $random(seed);
      apb_write(io_addr(sel), data, 4'hF, err);
      check_flag("pslverr", 1'b1, err);
      apb_read(io_addr(sel), rdata, err);
      check_flag("pslverr", 1'b1, err);
      check_value("prdata", 32'd0, rdata);
      check_value("leds", word_t'(led_model), word_t'(leds));
      check_flag("mtx_cs", 1'b1, mtx_cs);
    end
    finish_test("address_error", start_errors);

    checker_fails = soc_io_top_inst.soc_io_checker_inst.fail_count;
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_run, checks, errors, checker_fails);
    if (errors == 0 && checker_fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/apb_io_fsm.sv */
// APB slave FSM: one strobe per transfer, one-cycle response,
// stall of matrix data writes while the shifter is busy
`default_nettype none

module apb_io_fsm (
  input  logic clk,
  input  logic RESET,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic is_mtx_dat,
  input  logic busy,
  input  logic addr_err,
  output logic rd_stb,
  output logic wr_stb,
  output logic pready,
  output logic pslverr
);
  import soc_io_pkg::*;

  apb_state_t state;
  apb_state_t next_state;
  logic       err_q;
  logic       must_wait;

  // a new matrix word cannot be loaded until the previous one is out
  assign must_wait = pwrite && is_mtx_dat && busy;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        // setup cycle of a new transfer
        if (psel && !penable) begin
          next_state = must_wait ? STALL : STROBE;
        end
      end
      STALL: begin
        if (!busy) begin
          next_state = STROBE;
        end
      end
      STROBE:  next_state = RESPOND;
      RESPOND: next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      state <= IDLE;
      err_q <= 1'b0;
    end else begin
      state <= next_state;
      // error is decided by the address seen at the strobe
      if (state == STROBE) begin
        err_q <= addr_err;
      end
    end
  end

  assign rd_stb  = (state == STROBE) && !pwrite;
  assign wr_stb  = (state == STROBE) && pwrite;
  assign pready  = (state == RESPOND);
  assign pslverr = (state == RESPOND) && err_q;

endmodule

`default_nettype wire

/* verilog/io_regs.sv */
// IO page: one-hot register decode, LED register, button and status read,
// matrix data load and address error flag
`default_nettype none

module io_regs (
  input  logic                  clk,
  input  logic                  RESET,
  input  soc_io_pkg::io_sel_t   io_addr,
  input  logic                  wr,
  input  logic                  rd,
  input  soc_io_pkg::word_t     wdata,
  input  soc_io_pkg::button_t   buttons,
  input  logic                  busy,
  output soc_io_pkg::word_t     rdata,
  output soc_io_pkg::led_t      leds,
  output logic                  mtx_load,
  output soc_io_pkg::mtx_word_t mtx_data,
  output logic                  is_mtx_dat,
  output logic                  addr_err
);
  import soc_io_pkg::*;

  logic  onehot;
  logic  wr_ok;
  word_t rd_val;

  // exactly one select bit set
  assign onehot = (io_addr != '0) && ((io_addr & (io_addr - 1'b1)) == '0);

  assign addr_err   = !onehot;
  assign is_mtx_dat = onehot && io_addr[MTX_DAT_BIT];
  assign wr_ok      = wr && onehot;

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      leds <= '0;
    end else if (wr_ok && io_addr[LEDS_BIT]) begin
      leds <= wdata[$bits(led_t)-1:0];
    end
  end

  // the shifter captures the word itself
  assign mtx_load = wr_ok && io_addr[MTX_DAT_BIT];
  assign mtx_data = wdata[MTX_BITS-1:0];

  // matrix data is write only and reads as zero, like a bad select
  always_comb begin
    rd_val = '0;
    if (onehot) begin
      if (io_addr[LEDS_BIT]) begin
        rd_val = word_t'(leds);
      end
      if (io_addr[BUTTONS_BIT]) begin
        rd_val = word_t'(buttons);
      end
      if (io_addr[MTX_CNTL_BIT]) begin
        rd_val = word_t'(busy);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      rdata <= rd_val;
    end
  end

endmodule

`default_nettype wire

/* verilog/matrix_shifter.sv */
// serial shifter for the LED matrix driver, MSB first,
// with bit counter, active-low chip select and serial clock pulse
`default_nettype none

module matrix_shifter (
  input  logic                  clk,
  input  logic                  RESET,
  input  logic                  load,
  input  soc_io_pkg::mtx_word_t load_data,
  input  logic                  tick,
  output logic                  busy,
  output logic                  mtx_din,
  output logic                  mtx_clk,
  output logic                  mtx_cs
);
  import soc_io_pkg::*;

  localparam int CNT_W = $clog2(MTX_BITS + 1);

  mtx_word_t        shreg;
  // bits still to send, zero means idle
  logic [CNT_W-1:0] bit_cnt;

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      bit_cnt <= '0;
    end else if (load) begin
      bit_cnt <= CNT_W'(MTX_BITS);
    end else if (busy && tick) begin
      bit_cnt <= bit_cnt - 1'b1;
    end
  end

  // shift after the bit has been clocked out
  always_ff @(posedge clk) begin
    if (load) begin
      shreg <= load_data;
    end else if (busy && tick) begin
      shreg <= {shreg[MTX_BITS-2:0], 1'b0};
    end
  end

  assign busy    = (bit_cnt != '0);
  assign mtx_cs  = !busy;
  assign mtx_clk = busy && tick;
  assign mtx_din = busy && shreg[MTX_BITS-1];

endmodule

`default_nettype wire

/* verilog/serial_clk_divider.sv */
// divider producing one serial bit tick every DIV_RATIO cycles while enabled
`default_nettype none

module serial_clk_divider #(
  parameter int DIV_RATIO = 4
) (
  input  logic clk,
  input  logic RESET,
  input  logic enable,
  output logic tick
);

  localparam int CNT_W = $clog2(DIV_RATIO);

  logic [CNT_W-1:0] count;
  logic             wrap;

  assign wrap = (count == CNT_W'(DIV_RATIO - 1));

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      count <= '0;
      tick  <= 1'b0;
    end else if (!enable) begin
      // restart so the next word starts with a full bit period
      count <= '0;
      tick  <= 1'b0;
    end else begin
      count <= wrap ? '0 : count + 1'b1;
      tick  <= wrap;
    end
  end

endmodule

`default_nettype wire

/* verilog/soc_io_pkg.sv */
// shared types for the memory and IO subsystem
// data word, strobe and peripheral widths, IO select bits, APB FSM states
`default_nettype none

package soc_io_pkg;

  // one APB / RAM data word and its byte lanes
  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;

  // peripheral widths
  typedef logic [3:0] led_t;
  typedef logic [5:0] button_t;

  // bits per serial transfer to the matrix driver
  localparam int MTX_BITS = 16;
  typedef logic [MTX_BITS-1:0] mtx_word_t;

  // one-hot IO register select, one register per word-address bit
  typedef logic [3:0] io_sel_t;

  localparam int LEDS_BIT     = 0;  // read/write
  localparam int BUTTONS_BIT  = 1;  // read only
  localparam int MTX_CNTL_BIT = 2;  // read only, busy in bit 0
  localparam int MTX_DAT_BIT  = 3;  // write only, 16-bit word

  // APB slave transfer sequencing
  typedef enum logic [1:0] {
    IDLE,
    STROBE,
    STALL,
    RESPOND
  } apb_state_t;

endpackage

`default_nettype wire

/* verilog/soc_io_top.sv */
// memory and IO subsystem top: APB slave, RAM page, IO page and matrix serial port
`default_nettype none

module soc_io_top #(
  parameter int RAM_ADDR_W = 8,
  parameter int DIV_RATIO  = 4
) (
  input  logic                  clk,
  input  logic                  RESET,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [RAM_ADDR_W+2:0] paddr,
  input  soc_io_pkg::word_t     pwdata,
  input  soc_io_pkg::strb_t     pstrb,
  output soc_io_pkg::word_t     prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  soc_io_pkg::button_t   buttons,
  output soc_io_pkg::led_t      leds,
  output logic                  mtx_din,
  output logic                  mtx_clk,
  output logic                  mtx_cs
);
  import soc_io_pkg::*;

  logic      is_io;
  logic      page_q;
  logic      rd_stb;
  logic      wr_stb;
  io_sel_t   io_addr;
  word_t     ram_rdata;
  word_t     io_rdata;
  logic      io_is_mtx_dat;
  logic      io_addr_err;
  logic      busy;
  logic      tick;
  logic      mtx_load;
  mtx_word_t mtx_data;

  // top address bit picks the IO page
  assign is_io   = paddr[RAM_ADDR_W+2];
  assign io_addr = paddr[2 +: $bits(io_sel_t)];

  // remember which page answered so prdata follows the strobe
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      page_q <= 1'b0;
    end else if (rd_stb || wr_stb) begin
      page_q <= is_io;
    end
  end

  assign prdata = page_q ? io_rdata : ram_rdata;

  apb_io_fsm apb_io_fsm_inst (
    .clk        (clk),
    .RESET      (RESET),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .is_mtx_dat (is_io && io_is_mtx_dat),
    .busy       (busy),
    .addr_err   (is_io && io_addr_err),
    .rd_stb     (rd_stb),
    .wr_stb     (wr_stb),
    .pready     (pready),
    .pslverr    (pslverr)
  );

  word_ram #(
    .RAM_ADDR_W (RAM_ADDR_W)
  ) word_ram_inst (
    .clk       (clk),
    .we        (wr_stb && !is_io),
    .strb      (pstrb),
    .word_addr (paddr[RAM_ADDR_W+1:2]),
    .wdata     (pwdata),
    .rd        (rd_stb && !is_io),
    .rdata     (ram_rdata)
  );

  io_regs io_regs_inst (
    .clk        (clk),
    .RESET      (RESET),
    .io_addr    (io_addr),
    .wr         (wr_stb && is_io),
    .rd         (rd_stb && is_io),
    .wdata      (pwdata),
    .buttons    (buttons),
    .busy       (busy),
    .rdata      (io_rdata),
    .leds       (leds),
    .mtx_load   (mtx_load),
    .mtx_data   (mtx_data),
    .is_mtx_dat (io_is_mtx_dat),
    .addr_err   (io_addr_err)
  );

  serial_clk_divider #(
    .DIV_RATIO (DIV_RATIO)
  ) serial_clk_divider_inst (
    .clk    (clk),
    .RESET  (RESET),
    .enable (busy),
    .tick   (tick)
  );

  matrix_shifter matrix_shifter_inst (
    .clk       (clk),
    .RESET     (RESET),
    .load      (mtx_load),
    .load_data (mtx_data),
    .tick      (tick),
    .busy      (busy),
    .mtx_din   (mtx_din),
    .mtx_clk   (mtx_clk),
    .mtx_cs    (mtx_cs)
  );

endmodule

`default_nettype wire

/* verilog/word_ram.sv */
// single-port word RAM with byte write strobes and registered read
`default_nettype none

module word_ram #(
  parameter int RAM_ADDR_W = 8
) (
  input  logic                  clk,
  input  logic                  we,
  input  soc_io_pkg::strb_t     strb,
  input  logic [RAM_ADDR_W-1:0] word_addr,
  input  soc_io_pkg::word_t     wdata,
  input  logic                  rd,
  output soc_io_pkg::word_t     rdata
);
  import soc_io_pkg::*;

  localparam int DEPTH = 1 << RAM_ADDR_W;

  word_t mem [DEPTH];

  // only the strobed byte lanes change
  always_ff @(posedge clk) begin
    if (we) begin
      for (int lane = 0; lane < $bits(strb_t); lane++) begin
        if (strb[lane]) begin
          mem[word_addr][lane*8 +: 8] <= wdata[lane*8 +: 8];
        end
      end
    end
  end

  // read data valid the cycle after rd
  always_ff @(posedge clk) begin
    if (rd) begin
      rdata <= mem[word_addr];
    end
  end

endmodule

`default_nettype wire
